// File: Makefile
# Verilator build and run for simple_video

VERILATOR ?= verilator
TOP       ?= video_tb
FILELIST  ?= simple_video.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
		echo "simulation run failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/video_tb.sv
/*
 * testbench for the video controller
 *   clock, reset, vram model with random latency and ready
 *   cpu write task, palette model, directed tests
 *   value checker and watchdog
 */
`timescale 1ns/1ps

module video_tb;

	localparam int CLK_PERIOD = 10;
	localparam int FRAME_CLKS = int'(video_pkg::H_TOTAL) * int'(video_pkg::V_TOTAL);
	localparam int WRITE_CLKS = 4;
	// index write, 256 triplets, then the seven writes of the index reset test
	localparam int CPU_WRITES = 1 + 3 * 256 + 7;
	// raster 2 frames, two pixel tests of up to 3 frames each, plus slack
	localparam int LIMIT_CLKS = 10 * FRAME_CLKS + CPU_WRITES * WRITE_CLKS + 100;
	localparam int VRAM_WORDS = 64;

	logic                 clk;
	logic                 reset_n;
	video_pkg::cpu_bus_t  cpu;
	video_pkg::vram_req_t vram_req;
	logic                 vram_ready;
	video_pkg::vram_rsp_t vram_rsp;
	video_pkg::rgb_t      video;
	logic                 de;
	logic                 hs;
	logic                 vs;

	// vram contents and the expected palette
	logic [31:0]     vram_mem [0:VRAM_WORDS-1];
	video_pkg::rgb_t pal_model [0:255];
	int              errors;
	int              checks;

	video_top uut (
		.clk        (clk),
		.reset_n    (reset_n),
		.cpu        (cpu),
		.vram_req   (vram_req),
		.vram_ready (vram_ready),
		.vram_rsp   (vram_rsp),
		.video      (video),
		.de         (de),
		.hs         (hs),
		.vs         (vs)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ----------------------------------------
	// vram model
	// ----------------------------------------
	// one read in flight with data 1 to 4 clocks after accept
	initial begin : vram_model
		int         lat;
		logic [5:0] pend;
		vram_ready = 1'b0;
		vram_rsp   = '0;
		lat        = 0;
		pend       = '0;
		forever begin
			@(posedge clk);
			if (!reset_n) begin
				vram_ready <= 1'b0;
				vram_rsp   <= '0;
				lat        = 0;
			end else begin
				if (lat == 1) begin
					vram_rsp <= '{valid: 1'b1, data: vram_mem[pend]};
				end else begin
					vram_rsp <= '0;
				end
				if (lat > 0) begin
					lat--;
				end
				if (vram_req.valid && vram_ready) begin
					pend = vram_req.addr[5:0];
					lat  = 1 + int'($urandom % 4);
				end
				// ready drops at random but never two clocks in a row
				vram_ready <= !vram_ready || ($urandom % 4 != 0);
			end
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic expect_idle();
		check("de", 32'd0, de);
		check("hs", 32'd0, hs);
		check("vs", 32'd0, vs);
		check("video", 32'd0, video);
		check("vram_req.valid", 32'd0, vram_req.valid);
	endtask

	// one strobe cycle, completes on the rising wr_n
	task automatic cpu_write(input logic [7:0] port, input logic [7:0] value);
		@(posedge clk);
		cpu <= '{iorq_n: 1'b0, wr_n: 1'b0, address: port, wdata: value};
		repeat (2) @(posedge clk);
		cpu.iorq_n <= 1'b1;
		cpu.wr_n   <= 1'b1;
		@(posedge clk);
	endtask

	// returns on the first sample with vs just risen
	task automatic wait_frame_start();
		logic prev;
		prev = 1'b1;
		@(negedge clk);
		while (!(vs && !prev)) begin
			prev = vs;
			@(negedge clk);
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic reset_sequence();
		@(posedge clk);
		@(negedge clk);
		expect_idle();
		@(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		expect_idle();
		// first clock out of reset
		@(posedge clk);
		@(negedge clk);
		expect_idle();
	endtask

	task automatic measure_raster();
		int   hs_last;
		int   hs_run;
		int   vs_run;
		int   de_run;
		int   de_runs;
		logic hs_p;
		logic de_p;
		hs_last = -1;
		hs_run  = 0;
		vs_run  = 0;
		de_run  = 0;
		de_runs = 0;
		hs_p    = 1'b0;
		de_p    = 1'b0;
		wait_frame_start();
		for (int i = 0; i < FRAME_CLKS; i++) begin
			if (hs && !hs_p) begin
				if (hs_last >= 0) begin
					check("hs period", video_pkg::H_TOTAL, i - hs_last);
				end
				hs_last = i;
			end
			if (hs) begin
				hs_run++;
			end else if (hs_p) begin
				check("hs width", video_pkg::H_SYNC, hs_run);
				hs_run = 0;
			end
			if (vs) begin
				vs_run++;
			end
			if (de) begin
				de_run++;
			end else if (de_p) begin
				check("de run", video_pkg::H_RES, de_run);
				de_runs++;
				de_run = 0;
			end
			hs_p = hs;
			de_p = de;
			@(negedge clk);
		end
		check("vs width", video_pkg::V_SYNC * video_pkg::H_TOTAL, vs_run);
		check("de runs", video_pkg::V_RES, de_runs);
	endtask

	task automatic program_palette(input logic [7:0] start);
		video_pkg::rgb_t c;
		logic [7:0]      idx;
		cpu_write(video_pkg::PORT_PAL_INDEX, start);
		for (int i = 0; i < 256; i++) begin
			c   = video_pkg::rgb_t'(24'($urandom));
			idx = start + 8'(i);
			cpu_write(video_pkg::PORT_PAL_DATA, c.r);
			cpu_write(video_pkg::PORT_PAL_DATA, c.g);
			cpu_write(video_pkg::PORT_PAL_DATA, c.b);
			pal_model[idx] = c;
		end
	endtask

	// every pixel and the blanking of the second frame from now
	task automatic verify_frame();
		int              run;
		int              n;
		int              word;
		logic            de_p;
		logic [7:0]      pix;
		video_pkg::rgb_t exp_rgb;
		run  = 0;
		n    = 0;
		de_p = 1'b0;
		repeat (2) wait_frame_start();
		for (int i = 0; i < FRAME_CLKS; i++) begin
			if (de) begin
				word    = run * video_pkg::WORDS_PER_LINE + n / 4;
				pix     = vram_mem[word][8 * (n % 4) +: 8];
				exp_rgb = pal_model[pix];
				check("video.r", exp_rgb.r, video.r);
				check("video.g", exp_rgb.g, video.g);
				check("video.b", exp_rgb.b, video.b);
				n++;
			end else begin
				// black outside the active window
				check("video", 32'd0, video);
				if (de_p) begin
					run++;
					n = 0;
				end
			end
			de_p = de;
			@(negedge clk);
		end
	endtask

	task automatic index_reset_test();
		cpu_write(video_pkg::PORT_PAL_INDEX, 8'd5);
		cpu_write(video_pkg::PORT_PAL_DATA, 8'h11);
		cpu_write(video_pkg::PORT_PAL_DATA, 8'h22);
		// restart the triplet before blue
		cpu_write(video_pkg::PORT_PAL_INDEX, 8'd5);
		cpu_write(video_pkg::PORT_PAL_DATA, 8'ha5);
		cpu_write(video_pkg::PORT_PAL_DATA, 8'h5a);
		cpu_write(video_pkg::PORT_PAL_DATA, 8'hc3);
		pal_model[5] = '{r: 8'ha5, g: 8'h5a, b: 8'hc3};
		verify_frame();
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin : main
		errors  = 0;
		checks  = 0;
		reset_n = 1'b0;
		cpu     = '{iorq_n: 1'b1, wr_n: 1'b1, address: 8'h00, wdata: 8'h00};
		void'($urandom(94));
		for (int i = 0; i < VRAM_WORDS; i++) begin
			vram_mem[i] = $urandom;
		end
		// index 5 on several rows and byte lanes
		vram_mem[3][15:8]   = 8'd5;
		vram_mem[20][31:24] = 8'd5;
		vram_mem[45][7:0]   = 8'd5;
		vram_mem[62][23:16] = 8'd5;

		reset_sequence();
		measure_raster();
		program_palette(8'd200);
		verify_frame();
		index_reset_test();

		$display("tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(LIMIT_CLKS * CLK_PERIOD);
		$display("timeout: tests did not complete within %0d clocks", LIMIT_CLKS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: logic/cpu_port.sv
/*
 * cpu i/o write port
 *   strobe edge detection and port decode
 *   palette index with auto increment, r/g/b sequencing
 */
`timescale 1ns/1ps

module cpu_port (
	input  logic                  clk,
	input  logic                  reset_n,
	input  video_pkg::cpu_bus_t   cpu,
	output video_pkg::pal_write_t pal_write
);

	logic                         iorq_q;
	logic                         wr_q;
	logic                         wr_done;
	logic [7:0]                   addr_q;
	logic [7:0]                   wdata_q;
	logic [video_pkg::PIX_W-1:0]  index_q;
	logic [1:0]                   elem_q;
	logic [video_pkg::PIX_W-1:0]  r_q;
	logic [video_pkg::PIX_W-1:0]  g_q;
	logic                         pal_we;
	logic [video_pkg::PIX_W-1:0]  pal_index;
	video_pkg::rgb_t              pal_rgb;
	logic                         sel_index;
	logic                         sel_data;

	// ----------------------------------------
	// strobe capture
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			iorq_q <= 1'b1;
			wr_q   <= 1'b1;
		end else begin
			iorq_q <= cpu.iorq_n;
			wr_q   <= cpu.wr_n;
		end
	end

	// bus held while wr_n low
	always_ff @(posedge clk) begin
		if (!cpu.wr_n) begin
			addr_q  <= cpu.address;
			wdata_q <= cpu.wdata;
		end
	end

	// rising edge of wr_n ends the cycle
	assign wr_done   = !iorq_q && !wr_q && cpu.wr_n;
	assign sel_index = wr_done && (addr_q == video_pkg::PORT_PAL_INDEX);
	assign sel_data  = wr_done && (addr_q == video_pkg::PORT_PAL_DATA);

	// ----------------------------------------
	// palette index and element
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			index_q <= '0;
			elem_q  <= 2'd0;
		end else if (sel_index) begin
			index_q <= wdata_q;
			elem_q  <= 2'd0;
		end else if (sel_data) begin
			if (elem_q == 2'd2) begin
				// blue closes the entry
				index_q <= index_q + 1'b1;
				elem_q  <= 2'd0;
			end else begin
				elem_q <= elem_q + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sel_data && elem_q == 2'd0) begin
			r_q <= wdata_q;
		end
		if (sel_data && elem_q == 2'd1) begin
			g_q <= wdata_q;
		end
		if (sel_data && elem_q == 2'd2) begin
			pal_index <= index_q;
			pal_rgb   <= '{r: r_q, g: g_q, b: wdata_q};
		end
	end

	// one clock pulse per blue byte
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pal_we <= 1'b0;
		end else begin
			pal_we <= sel_data && (elem_q == 2'd2);
		end
	end

	assign pal_write = '{we: pal_we, index: pal_index, rgb: pal_rgb};

	a_elem_range: assert property (@(posedge clk) disable iff (!reset_n)
		elem_q != 2'd3);

endmodule

// File: logic/line_buffer.sv
/*
 * ping-pong line buffer
 *   two banks of one row of pixel indexes
 *   byte write port, registered read port
 */
`timescale 1ns/1ps

module line_buffer (
	input  logic                        clk,
	input  video_pkg::line_write_t      line_write,
	input  logic                        rd_bank,
	input  video_pkg::line_x_t          rd_x,
	output logic [video_pkg::PIX_W-1:0] rd_pixel
);

	// bank select is the top address bit
	logic [video_pkg::PIX_W-1:0] mem [0:2*video_pkg::H_RES-1];

	// ----------------------------------------
	// write from the fetcher
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (line_write.we) begin
			mem[{line_write.bank, line_write.x}] <= line_write.data;
		end
	end

	// ----------------------------------------
	// read for display, one clock
	// ----------------------------------------
	always_ff @(posedge clk) begin
		rd_pixel <= mem[{rd_bank, rd_x}];
	end

	// fetcher and display always sit on opposite banks
	a_bank_split: assert property (@(posedge clk)
		line_write.we |-> (line_write.bank != rd_bank));

endmodule

// File: logic/palette_lookup.sv
/*
 * pixel output stage
 *   line buffer read address from the raster position
 *   256 entry dual port palette ram
 *   sync delay line and output register with blanking
 */
`timescale 1ns/1ps

module palette_lookup (
	input  logic                        clk,
	input  logic                        reset_n,
	input  video_pkg::timing_t          timing,
	input  video_pkg::pal_write_t       pal_write,
	input  logic [video_pkg::PIX_W-1:0] rd_pixel,
	output logic                        rd_bank,
	output video_pkg::line_x_t          rd_x,
	output video_pkg::rgb_t             video,
	output logic                        de,
	output logic                        hs,
	output logic                        vs
);

	logic [11:0]     disp_row;
	logic [11:0]     h_off;
	video_pkg::rgb_t pal_ram [0:2**video_pkg::PIX_W-1];
	video_pkg::rgb_t pal_rgb;
	logic [2:0]      de_d;
	logic [2:0]      hs_d;
	logic [2:0]      vs_d;

	// ----------------------------------------
	// buffer read address
	// ----------------------------------------
	assign disp_row = timing.v_count - (video_pkg::V_SYNC + video_pkg::V_BPORCH);
	assign h_off    = timing.h_count - (video_pkg::H_SYNC + video_pkg::H_BPORCH);
	// even rows in bank 0
	assign rd_bank  = disp_row[0];
	assign rd_x     = h_off[video_pkg::LINE_X_W-1:0];

	// ----------------------------------------
	// palette ram
	// ----------------------------------------
	// cpu side
	always_ff @(posedge clk) begin
		if (pal_write.we) begin
			pal_ram[pal_write.index] <= pal_write.rgb;
		end
	end

	// display side, index from the buffer
	always_ff @(posedge clk) begin
		pal_rgb <= pal_ram[rd_pixel];
	end

	// ----------------------------------------
	// sync delay and output
	// ----------------------------------------
	// stage 0 buffer, 1 palette, 2 output
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			de_d <= '0;
			hs_d <= '0;
			vs_d <= '0;
		end else begin
			de_d <= {de_d[1:0], timing.de};
			hs_d <= {hs_d[1:0], timing.hs};
			vs_d <= {vs_d[1:0], timing.vs};
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			video <= '0;
		end else if (de_d[1]) begin
			video <= pal_rgb;
		end else begin
			// black in blanking
			video <= '0;
		end
	end

	assign de = de_d[2];
	assign hs = hs_d[2];
	assign vs = vs_d[2];

endmodule

// File: logic/video_pkg.sv
/*
 * shared definitions for the video controller
 *   raster timing constants of the small test mode
 *   widths, counter types and cpu port numbers
 *   bus and record structs passed between blocks
 */
package video_pkg;

	// ----------------------------------------
	// raster timing, small mode
	// ----------------------------------------
	localparam logic [11:0] H_TOTAL  = 12'd64;
	localparam logic [11:0] H_SYNC   = 12'd4;
	localparam logic [11:0] H_BPORCH = 12'd12;
	localparam logic [11:0] H_RES    = 12'd32;
	localparam logic [11:0] V_TOTAL  = 12'd12;
	localparam logic [11:0] V_SYNC   = 12'd1;
	localparam logic [11:0] V_BPORCH = 12'd2;
	localparam logic [11:0] V_RES    = 12'd8;

	// ----------------------------------------
	// widths and addresses
	// ----------------------------------------
	localparam int PIX_W          = 8;
	localparam int WORD_BYTES     = 4;
	localparam int WORDS_PER_LINE = int'(H_RES) / WORD_BYTES;
	localparam int VRAM_ADDR_W    = 21;
	localparam int LINE_X_W       = $clog2(int'(H_RES));
	localparam int WORD_CNT_W     = $clog2(WORDS_PER_LINE) + 1;
	localparam int BYTE_CNT_W     = $clog2(WORD_BYTES) + 1;

	// cpu i/o ports
	localparam logic [7:0] PORT_PAL_INDEX = 8'h20;
	localparam logic [7:0] PORT_PAL_DATA  = 8'h21;

	typedef logic [LINE_X_W-1:0]    line_x_t;
	typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
	typedef logic [WORD_CNT_W-1:0]  word_cnt_t;
	typedef logic [BYTE_CNT_W-1:0]  byte_cnt_t;

	typedef struct packed {
		logic [PIX_W-1:0] r;
		logic [PIX_W-1:0] g;
		logic [PIX_W-1:0] b;
	} rgb_t;

	// raw cpu strobes, active low
	typedef struct packed {
		logic       iorq_n;
		logic       wr_n;
		logic [7:0] address;
		logic [7:0] wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic             we;
		logic [PIX_W-1:0] index;
		rgb_t             rgb;
	} pal_write_t;

	typedef struct packed {
		logic       valid;
		vram_addr_t addr;
	} vram_req_t;

	typedef struct packed {
		logic                        valid;
		logic [WORD_BYTES*PIX_W-1:0] data;
	} vram_rsp_t;

	typedef struct packed {
		logic             we;
		logic             bank;
		line_x_t          x;
		logic [PIX_W-1:0] data;
	} line_write_t;

	// raster position, one clock behind the counters
	typedef struct packed {
		logic [11:0] h_count;
		logic [11:0] v_count;
		logic        de;
		logic        hs;
		logic        vs;
		logic        line_start;
		logic        fetch_valid;
		logic [11:0] fetch_row;
	} timing_t;

endpackage

// File: logic/video_timing.sv
/*
 * raster timing generator
 *   free running horizontal and vertical counters
 *   registered sync, data enable and line start flags
 *   row number of the next active line for the fetcher
 */
`timescale 1ns/1ps

module video_timing (
	input  logic               clk,
	input  logic               reset_n,
	output video_pkg::timing_t timing
);

	logic [11:0] h_cnt;
	logic [11:0] v_cnt;
	logic [11:0] v_next;
	logic [11:0] next_row;
	logic        h_end;
	logic        v_end;
	logic        h_win;
	logic        v_win;
	logic        next_win;

	assign h_end = (h_cnt == video_pkg::H_TOTAL - 12'd1);
	assign v_end = (v_cnt == video_pkg::V_TOTAL - 12'd1);

	// ----------------------------------------
	// counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			h_cnt <= 12'd0;
		end else if (h_end) begin
			h_cnt <= 12'd0;
		end else begin
			h_cnt <= h_cnt + 12'd1;
		end
	end

	// vertical steps once per line
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			v_cnt <= 12'd0;
		end else if (h_end) begin
			v_cnt <= v_next;
		end
	end

	assign v_next = v_end ? 12'd0 : v_cnt + 12'd1;

	// ----------------------------------------
	// window compares
	// ----------------------------------------
	assign h_win = (h_cnt >= video_pkg::H_SYNC + video_pkg::H_BPORCH) &&
		(h_cnt < video_pkg::H_SYNC + video_pkg::H_BPORCH + video_pkg::H_RES);
	assign v_win = (v_cnt >= video_pkg::V_SYNC + video_pkg::V_BPORCH) &&
		(v_cnt < video_pkg::V_SYNC + video_pkg::V_BPORCH + video_pkg::V_RES);

	// same window, one line ahead
	assign next_win = (v_next >= video_pkg::V_SYNC + video_pkg::V_BPORCH) &&
		(v_next < video_pkg::V_SYNC + video_pkg::V_BPORCH + video_pkg::V_RES);
	assign next_row = v_next - (video_pkg::V_SYNC + video_pkg::V_BPORCH);

	// ----------------------------------------
	// registered timing bus
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			timing <= '0;
		end else begin
			timing.h_count     <= h_cnt;
			timing.v_count     <= v_cnt;
			// hs leads each line, vs covers whole lines
			timing.hs          <= (h_cnt < video_pkg::H_SYNC);
			timing.vs          <= (v_cnt < video_pkg::V_SYNC);
			timing.de          <= h_win && v_win;
			timing.line_start  <= (h_cnt == 12'd0);
			timing.fetch_valid <= next_win;
			timing.fetch_row   <= next_row;
		end
	end

	// raster position seen by the fetcher and the pixel path stays in the frame
	a_v_range: assert property (@(posedge clk) disable iff (!reset_n)
		timing.v_count < video_pkg::V_TOTAL);

endmodule

// File: logic/video_top.sv
/*
 * video controller top
 *   timing, cpu port, vram fetch, line buffer, palette
 */
`timescale 1ns/1ps

module video_top (
	input  logic                 clk,
	input  logic                 reset_n,
	input  video_pkg::cpu_bus_t  cpu,
	output video_pkg::vram_req_t vram_req,
	input  logic                 vram_ready,
	input  video_pkg::vram_rsp_t vram_rsp,
	output video_pkg::rgb_t      video,
	output logic                 de,
	output logic                 hs,
	output logic                 vs
);

	video_pkg::timing_t          timing;
	video_pkg::pal_write_t       pal_write;
	video_pkg::line_write_t      line_write;
	logic                        rd_bank;
	video_pkg::line_x_t          rd_x;
	logic [video_pkg::PIX_W-1:0] rd_pixel;

	// ----------------------------------------
	// raster and cpu side
	// ----------------------------------------
	video_timing u_timing (
		.clk     (clk),
		.reset_n (reset_n),
		.timing  (timing)
	);

	cpu_port u_cpu_port (
		.clk       (clk),
		.reset_n   (reset_n),
		.cpu       (cpu),
		.pal_write (pal_write)
	);

	// ----------------------------------------
	// pixel path
	// ----------------------------------------
	vram_fetch u_fetch (
		.clk        (clk),
		.reset_n    (reset_n),
		.timing     (timing),
		.vram_req   (vram_req),
		.vram_ready (vram_ready),
		.vram_rsp   (vram_rsp),
		.line_write (line_write)
	);

	line_buffer u_line_buffer (
		.clk        (clk),
		.line_write (line_write),
		.rd_bank    (rd_bank),
		.rd_x       (rd_x),
		.rd_pixel   (rd_pixel)
	);

	palette_lookup u_palette (
		.clk       (clk),
		.reset_n   (reset_n),
		.timing    (timing),
		.pal_write (pal_write),
		.rd_pixel  (rd_pixel),
		.rd_bank   (rd_bank),
		.rd_x      (rd_x),
		.video     (video),
		.de        (de),
		.hs        (hs),
		.vs        (vs)
	);

endmodule

// File: logic/vram_fetch.sv
/*
 * vram row fetcher
 *   one read request outstanding, variable latency data
 *   hold register plus byte shifter into the line buffer
 */
`timescale 1ns/1ps

module vram_fetch (
	input  logic                   clk,
	input  logic                   reset_n,
	input  video_pkg::timing_t     timing,
	output video_pkg::vram_req_t   vram_req,
	input  logic                   vram_ready,
	input  video_pkg::vram_rsp_t   vram_rsp,
	output video_pkg::line_write_t line_write
);

	logic [11:0]                                       row_q;
	video_pkg::word_cnt_t                              word_cnt;
	logic                                              req_valid;
	video_pkg::vram_addr_t                             req_addr;
	logic                                              wait_q;
	logic [video_pkg::WORD_BYTES*video_pkg::PIX_W-1:0] hold_q;
	logic [video_pkg::WORD_BYTES*video_pkg::PIX_W-1:0] shift_q;
	logic                                              hold_v;
	logic                                              hold_next;
	video_pkg::byte_cnt_t                              shift_cnt;
	video_pkg::line_x_t                                x_q;
	logic                                              issue_left;
	logic                                              shift_free;
	logic                                              byte_out;
	logic                                              issue;
	logic                                              start;
	logic                                              busy;

	assign start      = timing.line_start && timing.fetch_valid;
	assign issue_left = word_cnt != video_pkg::word_cnt_t'(video_pkg::WORDS_PER_LINE);
	// shifter takes a word when empty or on its last byte
	assign shift_free = shift_cnt <= video_pkg::byte_cnt_t'(1);
	assign byte_out   = shift_cnt != '0;

	// hold slot state after this clock
	always_comb begin
		hold_next = hold_v;
		if (shift_free && hold_v) begin
			hold_next = vram_rsp.valid;
		end else if (vram_rsp.valid && !shift_free) begin
			hold_next = 1'b1;
		end
	end

	// next read only once a slot is sure to be free for its data
	assign issue = issue_left && !req_valid && (!wait_q || vram_rsp.valid) && !hold_next;
	assign busy  = issue_left || req_valid || wait_q || hold_v || byte_out;

	// ----------------------------------------
	// request side
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (start) begin
			row_q <= timing.fetch_row;
		end
		if (issue) begin
			req_addr <= video_pkg::vram_addr_t'(row_q) *
				video_pkg::vram_addr_t'(video_pkg::WORDS_PER_LINE) +
				video_pkg::vram_addr_t'(word_cnt);
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			word_cnt  <= video_pkg::word_cnt_t'(video_pkg::WORDS_PER_LINE);
			req_valid <= 1'b0;
			wait_q    <= 1'b0;
		end else begin
			if (start) begin
				word_cnt <= '0;
			end else if (issue) begin
				word_cnt <= word_cnt + 1'b1;
			end
			// valid held until accepted
			if (issue) begin
				req_valid <= 1'b1;
			end else if (vram_ready) begin
				req_valid <= 1'b0;
			end
			if (req_valid && vram_ready) begin
				wait_q <= 1'b1;
			end else if (vram_rsp.valid) begin
				wait_q <= 1'b0;
			end
		end
	end

	assign vram_req = '{valid: req_valid, addr: req_addr};

	// ----------------------------------------
	// data side, lowest byte first
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (shift_free && hold_v) begin
			shift_q <= hold_q;
		end else if (shift_free && vram_rsp.valid) begin
			shift_q <= vram_rsp.data;
		end else begin
			shift_q <= shift_q >> video_pkg::PIX_W;
		end
		if (vram_rsp.valid && (hold_v || !shift_free)) begin
			hold_q <= vram_rsp.data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			hold_v    <= 1'b0;
			shift_cnt <= '0;
			x_q       <= '0;
		end else begin
			hold_v <= hold_next;
			if (shift_free && (hold_v || vram_rsp.valid)) begin
				shift_cnt <= video_pkg::byte_cnt_t'(video_pkg::WORD_BYTES);
			end else if (byte_out) begin
				shift_cnt <= shift_cnt - 1'b1;
			end
			if (timing.line_start) begin
				x_q <= '0;
			end else if (byte_out) begin
				x_q <= x_q + 1'b1;
			end
		end
	end

	assign line_write = '{we: byte_out, bank: row_q[0], x: x_q,
		data: shift_q[video_pkg::PIX_W-1:0]};

	// whole row lands before the next line begins
	a_fetch_done: assert property (@(posedge clk) disable iff (!reset_n)
		timing.line_start |-> !busy);

endmodule

// File: simple_video.f
logic/video_pkg.sv
logic/video_timing.sv
logic/cpu_port.sv
logic/vram_fetch.sv
logic/line_buffer.sv
logic/palette_lookup.sv
logic/video_top.sv
bench/video_tb.sv
